// File: compile.f
logic/cpu_pkg.sv
logic/cmd_fetch.sv
logic/operand_read.sv
logic/alu.sv
logic/result_write.sv
logic/mem_bus_arbiter.sv
logic/cpu_core.sv
tests/mem_model.sv
tests/cpu_core_tb.sv

// File: logic/alu.sv
`timescale 1ns/1ns
`default_nettype none

module alu import cpu_pkg::*; (
  input  wire           clk,
  input  wire           rst_n,
  input  operand_item_t in_item,
  input  wire           in_valid,
  output logic          in_ready,
  input  addr_t         base_addr_data,
  output result_item_t  out_item,
  output logic          out_valid,
  input  wire           out_ready,
  output pending_t      pending
);

  data_t s1;
  data_t s0;
  data_t value;

  assign s1 = in_item.src1_val;
  assign s0 = in_item.src0_val;

  // all arithmetic wraps at 32 bits
  always_comb begin
    case (in_item.cmd.code)
      CMD_ADD: value = s1 + s0;
      CMD_SUB: value = s1 - s0;
      CMD_AND: value = s1 & s0;
      CMD_OR:  value = s1 | s0;
      CMD_XOR: value = s1 ^ s0;
      CMD_SHL: value = s1 << s0[4:0];
      CMD_MOV: value = s1;
      default: value = '0;
    endcase
  end

  assign in_ready = !out_valid || out_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) out_valid <= 1'b0;
    else if (in_ready) out_valid <= in_valid;
  end

  always_ff @(posedge clk) begin
    if (in_valid && in_ready) begin
      out_item.dst   <= base_addr_data + in_item.cmd.dst;
      out_item.value <= value;
      out_item.last  <= in_item.last;
      out_item.skip  <= (in_item.cmd.code == CMD_STOP);
    end
  end

  // held result not yet written
  assign pending.valid = out_valid && !out_item.skip;
  assign pending.dst   = out_item.dst[OFFS_W-1:0];

  a_known_code: assert property (@(posedge clk) disable iff (!rst_n)
    in_valid |-> in_item.cmd.code inside {CMD_ADD, CMD_SUB, CMD_AND, CMD_OR,
                                          CMD_XOR, CMD_SHL, CMD_MOV, CMD_STOP});

endmodule

`default_nettype wire

// File: logic/cmd_fetch.sv
`timescale 1ns/1ns
`default_nettype none

module cmd_fetch import cpu_pkg::*; (
  input  wire         clk,
  input  wire         rst_n,
  input  wire         start,
  input  addr_t       base_addr,
  output bus_req_t    req,
  input  wire         grant_done,
  input  data_t       rd_data,
  output fetch_item_t out_item,
  output logic        out_valid,
  input  wire         out_ready
);

  fetch_state_t state;
  addr_t        ip;
  fetch_item_t  item;
  command_t     word;

  assign word = command_t'(rd_data);

  // one read per command word
  assign req.read  = (state == F_REQ);
  assign req.write = 1'b0;
  assign req.addr  = base_addr + ip;
  assign req.data  = '0;

  assign out_valid = (state == F_WAIT_OUT);
  assign out_item  = item;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= F_IDLE;
      ip    <= '0;
    end else begin
      case (state)
        F_IDLE, F_HALT: begin
          if (start) begin
            ip    <= '0;
            state <= F_REQ;
          end
        end
        F_REQ: begin
          if (grant_done) begin
            ip    <= ip + addr_t'(1);
            state <= F_WAIT_OUT;
          end
        end
        F_WAIT_OUT: begin
          // stop fetching once STOP has been handed on
          if (out_ready) state <= item.last ? F_HALT : F_REQ;
        end
        default: state <= F_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == F_REQ && grant_done) begin
      item.cmd  <= word;
      item.last <= (word.code == CMD_STOP);
    end
  end

  a_start_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
    start |-> (state == F_IDLE || state == F_HALT));

endmodule

`default_nettype wire

// File: logic/cpu_core.sv
`timescale 1ns/1ns
`default_nettype none

module cpu_core import cpu_pkg::*; (
  input  wire   clk,
  input  wire   rst_n,
  input  wire   start,
  input  addr_t base_addr,
  input  addr_t base_addr_data,
  output logic  read_q,
  output logic  write_q,
  input  wire   read_dn,
  input  wire   write_dn,
  output addr_t addr_out,
  output data_t data_out,
  input  data_t data_in,
  output logic  busy,
  output logic  done
);

  fetch_item_t   f_item;
  operand_item_t o_item;
  result_item_t  a_item;
  logic          f_valid, f_ready;
  logic          o_valid, o_ready;
  logic          a_valid, a_ready;
  bus_req_t      fetch_req, opread_req, write_req;
  logic          fetch_done, opread_done, write_done;
  data_t         rd_data;
  pending_t      alu_pending, wr_pending;

  cmd_fetch i_cmd_fetch (
    .clk(clk), .rst_n(rst_n), .start(start), .base_addr(base_addr),
    .req(fetch_req), .grant_done(fetch_done), .rd_data(rd_data),
    .out_item(f_item), .out_valid(f_valid), .out_ready(f_ready)
  );

  operand_read i_operand_read (
    .clk(clk), .rst_n(rst_n),
    .in_item(f_item), .in_valid(f_valid), .in_ready(f_ready),
    .base_addr_data(base_addr_data),
    .alu_pending(alu_pending), .wr_pending(wr_pending),
    .req(opread_req), .grant_done(opread_done), .rd_data(rd_data),
    .out_item(o_item), .out_valid(o_valid), .out_ready(o_ready)
  );

  alu i_alu (
    .clk(clk), .rst_n(rst_n),
    .in_item(o_item), .in_valid(o_valid), .in_ready(o_ready),
    .base_addr_data(base_addr_data),
    .out_item(a_item), .out_valid(a_valid), .out_ready(a_ready),
    .pending(alu_pending)
  );

  result_write i_result_write (
    .clk(clk), .rst_n(rst_n), .start(start),
    .in_item(a_item), .in_valid(a_valid), .in_ready(a_ready),
    .req(write_req), .grant_done(write_done), .pending(wr_pending),
    .busy(busy), .done(done)
  );

  // single memory port shared by three stages
  mem_bus_arbiter i_mem_bus_arbiter (
    .clk(clk), .rst_n(rst_n),
    .fetch_req(fetch_req), .opread_req(opread_req), .write_req(write_req),
    .fetch_done(fetch_done), .opread_done(opread_done), .write_done(write_done),
    .rd_data(rd_data),
    .read_q(read_q), .write_q(write_q), .read_dn(read_dn), .write_dn(write_dn),
    .addr_out(addr_out), .data_out(data_out), .data_in(data_in)
  );

endmodule

`default_nettype wire

// File: logic/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

  localparam int ADDR_W = 16;
  localparam int DATA_W = 32;
  localparam int OFFS_W = 8;
  localparam int CODE_W = 4;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [OFFS_W-1:0] offs_t;

  // top four bits of a command word
  typedef enum logic [CODE_W-1:0] {
    CMD_ADD  = 4'h0,
    CMD_SUB  = 4'h1,
    CMD_AND  = 4'h2,
    CMD_OR   = 4'h3,
    CMD_XOR  = 4'h4,
    CMD_SHL  = 4'h5,
    CMD_MOV  = 4'h6,
    CMD_STOP = 4'h7
  } cmd_code_t;

  // code | dst | src1 | src0 | spare, msb first
  typedef struct packed {
    cmd_code_t  code;
    offs_t      dst;
    offs_t      src1;
    offs_t      src0;
    logic [3:0] spare;
  } command_t;

  typedef struct packed {
    command_t cmd;
    logic     last;
  } fetch_item_t;

  typedef struct packed {
    command_t cmd;
    logic     last;
    data_t    src1_val;
    data_t    src0_val;
  } operand_item_t;

  typedef struct packed {
    addr_t dst;
    data_t value;
    logic  last;
    logic  skip;
  } result_item_t;

  // dst holds the low byte of the absolute destination address
  typedef struct packed {
    logic  valid;
    offs_t dst;
  } pending_t;

  typedef struct packed {
    logic  read;
    logic  write;
    addr_t addr;
    data_t data;
  } bus_req_t;

  typedef enum logic [1:0] {F_IDLE, F_REQ, F_WAIT_OUT, F_HALT} fetch_state_t;

  typedef enum logic [1:0] {O_IDLE, O_RD1, O_RD0, O_OUT} opread_state_t;

endpackage

`default_nettype wire

// File: logic/mem_bus_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

module mem_bus_arbiter import cpu_pkg::*; (
  input  wire      clk,
  input  wire      rst_n,
  input  bus_req_t fetch_req,
  input  bus_req_t opread_req,
  input  bus_req_t write_req,
  output logic     fetch_done,
  output logic     opread_done,
  output logic     write_done,
  output data_t    rd_data,
  output logic     read_q,
  output logic     write_q,
  input  wire      read_dn,
  input  wire      write_dn,
  output addr_t    addr_out,
  output data_t    data_out,
  input  data_t    data_in
);

  typedef enum logic [1:0] {OWN_NONE, OWN_FETCH, OWN_OPREAD, OWN_WRITE} owner_t;

  owner_t   owner;
  owner_t   pick;
  bus_req_t cur;
  logic     active;
  logic     xfer_done;

  // oldest work first: write, then operand read, then fetch
  always_comb begin
    if (write_req.read || write_req.write) pick = OWN_WRITE;
    else if (opread_req.read || opread_req.write) pick = OWN_OPREAD;
    else if (fetch_req.read || fetch_req.write) pick = OWN_FETCH;
    else pick = OWN_NONE;
  end

  always_comb begin
    case (owner)
      OWN_FETCH:  cur = fetch_req;
      OWN_OPREAD: cur = opread_req;
      OWN_WRITE:  cur = write_req;
      default:    cur = '0;
    endcase
  end

  assign active    = (owner != OWN_NONE);
  assign read_q    = active && cur.read;
  assign write_q   = active && cur.write;
  assign addr_out  = active ? cur.addr : '0;
  assign data_out  = write_q ? cur.data : '0;
  assign xfer_done = (read_q && read_dn) || (write_q && write_dn);

  assign fetch_done  = xfer_done && owner == OWN_FETCH;
  assign opread_done = xfer_done && owner == OWN_OPREAD;
  assign write_done  = xfer_done && owner == OWN_WRITE;
  assign rd_data     = data_in;

  // locked until the memory answers
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) owner <= OWN_NONE;
    else if (!active) owner <= pick;
    else if (xfer_done) owner <= OWN_NONE;
  end

  a_one_direction: assert property (@(posedge clk) disable iff (!rst_n)
    !(read_q && write_q));

  a_owner_holds: assert property (@(posedge clk) disable iff (!rst_n)
    active |-> (cur.read || cur.write));

endmodule

`default_nettype wire

// File: logic/operand_read.sv
`timescale 1ns/1ns
`default_nettype none

module operand_read import cpu_pkg::*; (
  input  wire           clk,
  input  wire           rst_n,
  input  fetch_item_t   in_item,
  input  wire           in_valid,
  output logic          in_ready,
  input  addr_t         base_addr_data,
  input  pending_t      alu_pending,
  input  pending_t      wr_pending,
  output bus_req_t      req,
  input  wire           grant_done,
  input  data_t         rd_data,
  output operand_item_t out_item,
  output logic          out_valid,
  input  wire           out_ready
);

  opread_state_t state;
  operand_item_t item;
  addr_t         src_addr;
  logic          src_hazard;
  logic          reading;

  assign reading = (state == O_RD1 || state == O_RD0);

  // src1 first, then src0
  always_comb begin
    src_addr = base_addr_data + ((state == O_RD0) ? item.cmd.src0 : item.cmd.src1);
    // data addresses share one base, so the low byte identifies the word
    src_hazard = (alu_pending.valid && alu_pending.dst == src_addr[OFFS_W-1:0]) ||
                 (wr_pending.valid && wr_pending.dst == src_addr[OFFS_W-1:0]);
  end

  assign req.read  = reading && !src_hazard;
  assign req.write = 1'b0;
  assign req.addr  = src_addr;
  assign req.data  = '0;

  assign in_ready  = (state == O_IDLE);
  assign out_valid = (state == O_OUT);
  assign out_item  = item;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= O_IDLE;
    end else begin
      case (state)
        O_IDLE: begin
          if (in_valid) state <= (in_item.cmd.code == CMD_STOP) ? O_OUT : O_RD1;
        end
        O_RD1: begin
          // MOV has a single source
          if (grant_done) state <= (item.cmd.code == CMD_MOV) ? O_OUT : O_RD0;
        end
        O_RD0: begin
          if (grant_done) state <= O_OUT;
        end
        O_OUT: begin
          if (out_ready) state <= O_IDLE;
        end
        default: state <= O_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid && in_ready) begin
      item.cmd      <= in_item.cmd;
      item.last     <= in_item.last;
      item.src1_val <= '0;
      item.src0_val <= '0;
    end else if (grant_done && state == O_RD1) begin
      item.src1_val <= rd_data;
    end else if (grant_done && state == O_RD0) begin
      item.src0_val <= rd_data;
    end
  end

endmodule

`default_nettype wire

// File: logic/result_write.sv
`timescale 1ns/1ns
`default_nettype none

module result_write import cpu_pkg::*; (
  input  wire          clk,
  input  wire          rst_n,
  input  wire          start,
  input  result_item_t in_item,
  input  wire          in_valid,
  output logic         in_ready,
  output bus_req_t     req,
  input  wire          grant_done,
  output pending_t     pending,
  output logic         busy,
  output logic         done
);

  result_item_t held;
  logic         held_valid;

  assign in_ready = !held_valid;

  assign req.read  = 1'b0;
  assign req.write = held_valid;
  assign req.addr  = held.dst;
  assign req.data  = held.value;

  assign pending.valid = held_valid;
  assign pending.dst   = held.dst[OFFS_W-1:0];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      held_valid <= 1'b0;
      busy       <= 1'b0;
      done       <= 1'b0;
    end else begin
      done <= 1'b0;
      if (start) busy <= 1'b1;
      if (held_valid && grant_done) begin
        held_valid <= 1'b0;
      end
      // skip items retire on the spot
      if (in_valid && in_ready) begin
        if (!in_item.skip) begin
          held_valid <= 1'b1;
        end else if (in_item.last) begin
          done <= 1'b1;
          busy <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid && in_ready) held <= in_item;
  end

endmodule

`default_nettype wire

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module cpu_core_tb \
  -f compile.f -o cpu_core_sim || exit 1
out="$(./obj_dir/cpu_core_sim)"
echo "$out"
echo "$out" | grep -qx "Everything OK" && exit 0 || exit 1

// File: tests/cpu_core_tb.sv
`timescale 1ns/1ns
`default_nettype none

module cpu_core_tb import cpu_pkg::*; ();

  localparam int TOTAL_CMDS      = 42;
  localparam int CYCLES_PER_CMD  = 40;
  localparam int WATCHDOG_CYCLES = TOTAL_CMDS * CYCLES_PER_CMD + 1000;

  logic  clk;
  logic  rst_n;
  logic  start;
  addr_t base_addr;
  addr_t base_addr_data;
  logic  read_q;
  logic  write_q;
  logic  read_dn;
  logic  write_dn;
  addr_t addr_out;
  data_t data_out;
  data_t data_in;
  logic  busy;
  logic  done;
  int    writes;

  int          mismatches;
  int          failures;
  logic [31:0] lfsr;
  data_t       prog[$];
  data_t       ref_data[256];
  data_t       first_ref[256];

  cpu_core i_cpu_core (
    .clk(clk), .rst_n(rst_n), .start(start),
    .base_addr(base_addr), .base_addr_data(base_addr_data),
    .read_q(read_q), .write_q(write_q), .read_dn(read_dn), .write_dn(write_dn),
    .addr_out(addr_out), .data_out(data_out), .data_in(data_in),
    .busy(busy), .done(done)
  );

  mem_model i_mem (
    .clk(clk), .rst_n(rst_n), .read_q(read_q), .write_q(write_q),
    .addr(addr_out), .wdata(data_out), .read_dn(read_dn), .write_dn(write_dn),
    .rdata(data_in), .writes(writes)
  );

  initial clk = 1'b0;
  always #2 clk = ~clk;

  // fibonacci lfsr, taps 32 22 2 1
  function automatic logic [31:0] random_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      r = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  function automatic data_t fill_word(input addr_t a);
    return {a ^ 16'hc3a5, ~a};
  endfunction

  function automatic data_t make_cmd(input cmd_code_t code, input offs_t dst,
                                     input offs_t s1, input offs_t s0);
    return {code, dst, s1, s0, 4'h0};
  endfunction

  // reference rules of the command set
  function automatic data_t expected_value(input cmd_code_t code, input data_t a,
                                           input data_t b);
    case (code)
      CMD_ADD: return a + b;
      CMD_SUB: return a - b;
      CMD_AND: return a & b;
      CMD_OR:  return a | b;
      CMD_XOR: return a ^ b;
      CMD_SHL: return a << b[4:0];
      default: return a;
    endcase
  endfunction

  task automatic check_value(input string name, input data_t expected, input data_t actual);
    assert (actual == expected) else begin
      $display("MISMATCH %s: expected %h, actual %h", name, expected, actual);
      mismatches++;
    end
  endtask

  task automatic check_true(input string what, input logic cond);
    assert (cond) else begin
      $display("ERROR: %s", what);
      failures++;
    end
  endtask

  task automatic init_region(input addr_t base_d);
    for (int i = 0; i < 256; i++) begin
      ref_data[i] = fill_word(base_d + addr_t'(i));
    end
  endtask

  task automatic set_data(input addr_t base_d, input offs_t off, input data_t v);
    i_mem.mem[base_d + addr_t'(off)] = v;
    ref_data[off] = v;
  endtask

  task automatic compare_region(input string name, input addr_t base_d);
    for (int i = 0; i < 256; i++) begin
      check_value($sformatf("%s word %0d", name, i), ref_data[i],
                  i_mem.mem[base_d + addr_t'(i)]);
    end
  endtask

  task automatic run_program(input string name, input addr_t base, input addr_t base_d);
    int    stores;
    int    writes_before;
    int    cycles;
    data_t w;
    stores = 0;
    for (int i = 0; i < prog.size(); i++) begin
      i_mem.mem[base + addr_t'(i)] = prog[i];
    end
    // in-order reference run up to STOP
    for (int i = 0; i < prog.size(); i++) begin
      w = prog[i];
      if (w[31:28] == CMD_STOP) break;
      ref_data[w[27:20]] = expected_value(cmd_code_t'(w[31:28]), ref_data[w[19:12]],
                                          ref_data[w[11:4]]);
      stores++;
    end
    writes_before = writes;
    @(posedge clk);
    #1;
    base_addr      = base;
    base_addr_data = base_d;
    start          = 1'b1;
    @(posedge clk);
    #1;
    start = 1'b0;
    check_true($sformatf("%s: busy did not rise after start", name), busy);
    cycles = 0;
    while (!done && cycles < prog.size() * CYCLES_PER_CMD) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    if (!done) begin
      check_true($sformatf("%s: done did not arrive in %0d cycles", name, cycles), 1'b0);
    end else begin
      check_true($sformatf("%s: busy still high with done", name), !busy);
      @(posedge clk);
      #1;
      check_true($sformatf("%s: done longer than one cycle", name), !done);
    end
    compare_region(name, base_d);
    check_value($sformatf("%s write count", name), data_t'(stores),
                data_t'(writes - writes_before));
  endtask

  task automatic test_reset();
    check_true("read_q or write_q high after reset", !read_q && !write_q);
    check_true("busy or done high after reset", !busy && !done);
    check_value("reset addr_out", '0, data_t'(addr_out));
  endtask

  task automatic test_add();
    init_region(16'h4000);
    set_data(16'h4000, 8'd1, 32'hffff_fff0);
    set_data(16'h4000, 8'd2, 32'h0000_0025);
    prog.delete();
    prog.push_back(make_cmd(CMD_ADD, 8'd3, 8'd1, 8'd2));
    prog.push_back(make_cmd(CMD_STOP, 8'd4, 8'd1, 8'd2));
    run_program("add", 16'h0000, 16'h4000);
    // wraps past 2^32
    check_value("add hand value", 32'h0000_0015, i_mem.mem[16'h4003]);
  endtask

  task automatic test_codes();
    init_region(16'h4100);
    set_data(16'h4100, 8'd1, 32'hf0f0_1234);
    set_data(16'h4100, 8'd2, 32'h8000_0124);
    prog.delete();
    prog.push_back(make_cmd(CMD_SUB, 8'd10, 8'd1, 8'd2));
    prog.push_back(make_cmd(CMD_AND, 8'd11, 8'd1, 8'd2));
    prog.push_back(make_cmd(CMD_OR,  8'd12, 8'd1, 8'd2));
    prog.push_back(make_cmd(CMD_XOR, 8'd13, 8'd1, 8'd2));
    prog.push_back(make_cmd(CMD_SHL, 8'd14, 8'd1, 8'd2));
    prog.push_back(make_cmd(CMD_MOV, 8'd15, 8'd1, 8'd3));
    prog.push_back(make_cmd(CMD_STOP, 8'd20, 8'd1, 8'd2));
    run_program("codes", 16'h0100, 16'h4100);
    check_value("shl hand value", 32'h0f01_2340, i_mem.mem[16'h410e]);
  endtask

  // each command reads the previous destination
  task automatic test_chain();
    init_region(16'h4200);
    set_data(16'h4200, 8'd0, 32'd5);
    set_data(16'h4200, 8'd1, 32'd3);
    prog.delete();
    prog.push_back(make_cmd(CMD_ADD, 8'd2, 8'd0, 8'd1));
    prog.push_back(make_cmd(CMD_SUB, 8'd3, 8'd2, 8'd1));
    prog.push_back(make_cmd(CMD_SHL, 8'd4, 8'd3, 8'd1));
    prog.push_back(make_cmd(CMD_XOR, 8'd5, 8'd4, 8'd3));
    prog.push_back(make_cmd(CMD_ADD, 8'd5, 8'd5, 8'd4));
    prog.push_back(make_cmd(CMD_STOP, 8'd0, 8'd0, 8'd0));
    run_program("chain", 16'h0200, 16'h4200);
  endtask

  task automatic test_random();
    logic [3:0] code;
    init_region(16'h4300);
    for (int i = 0; i < 16; i++) begin
      set_data(16'h4300, offs_t'(i), random_bits(32));
    end
    prog.delete();
    for (int i = 0; i < 20; i++) begin
      code = 4'(random_bits(3) % 7);
      prog.push_back(make_cmd(cmd_code_t'(code), offs_t'(random_bits(4)),
                              offs_t'(random_bits(4)), offs_t'(random_bits(4))));
    end
    prog.push_back(make_cmd(CMD_STOP, 8'd0, 8'd0, 8'd0));
    run_program("random", 16'h0300, 16'h4300);
  endtask

  task automatic test_restart();
    init_region(16'h4400);
    set_data(16'h4400, 8'd0, 32'd7);
    set_data(16'h4400, 8'd1, 32'd9);
    prog.delete();
    prog.push_back(make_cmd(CMD_ADD, 8'd2, 8'd0, 8'd1));
    prog.push_back(make_cmd(CMD_XOR, 8'd3, 8'd2, 8'd0));
    prog.push_back(make_cmd(CMD_STOP, 8'd0, 8'd0, 8'd0));
    run_program("restart_a", 16'h0400, 16'h4400);
    first_ref = ref_data;
    init_region(16'h6000);
    set_data(16'h6000, 8'd0, 32'h1234_5678);
    prog.delete();
    prog.push_back(make_cmd(CMD_SUB, 8'd5, 8'd0, 8'd1));
    prog.push_back(make_cmd(CMD_OR,  8'd6, 8'd5, 8'd0));
    prog.push_back(make_cmd(CMD_STOP, 8'd0, 8'd0, 8'd0));
    run_program("restart_b", 16'h0800, 16'h6000);
    ref_data = first_ref;
    compare_region("restart_a_kept", 16'h4400);
  endtask

  always @(posedge clk) begin
    if (rst_n) begin
      check_true("read_q and write_q high together", !(read_q && write_q));
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("timeout: the core did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("Something failed");
    $finish;
  end

  initial begin
    rst_n          = 1'b0;
    start          = 1'b0;
    base_addr      = '0;
    base_addr_data = '0;
    mismatches     = 0;
    failures       = 0;
    lfsr           = 32'h4891;
    for (int a = 0; a < 65536; a++) begin
      i_mem.mem[a] = fill_word(addr_t'(a));
    end
    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;
    test_reset();
    test_add();
    test_codes();
    test_chain();
    test_random();
    test_restart();
    $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tests/mem_model.sv
`timescale 1ns/1ns
`default_nettype none

module mem_model import cpu_pkg::*; (
  input  wire   clk,
  input  wire   rst_n,
  input  wire   read_q,
  input  wire   write_q,
  input  addr_t addr,
  input  data_t wdata,
  output logic  read_dn,
  output logic  write_dn,
  output data_t rdata,
  output int    writes
);

  data_t       mem [0:65535];
  logic [31:0] lfsr;
  logic [1:0]  wait_cnt;
  logic        waiting;
  logic        respond;
  logic        is_read;
  logic        is_write;
  addr_t       req_addr;
  data_t       req_data;

  // fibonacci lfsr, taps 32 22 2 1, one step per bit
  function automatic logic [1:0] random_latency();
    logic [1:0] r;
    r = '0;
    for (int i = 0; i < 2; i++) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      r = {r[0], lfsr[0]};
    end
    return r;
  endfunction

  initial begin
    lfsr     = 32'h4891;
    read_dn  = 1'b0;
    write_dn = 1'b0;
    rdata    = '0;
    writes   = 0;
    waiting  = 1'b0;
    wait_cnt = '0;
  end

  // sample on the edge, answer 1 ns later
  always @(posedge clk) begin
    respond  = 1'b0;
    is_read  = read_q;
    is_write = write_q;
    req_addr = addr;
    req_data = wdata;
    if (!rst_n || read_dn || write_dn) begin
      waiting = 1'b0;
    end else if (is_read || is_write) begin
      if (!waiting) begin
        wait_cnt = random_latency();
        waiting  = 1'b1;
      end
      if (wait_cnt == 2'd0) begin
        respond = 1'b1;
      end else begin
        wait_cnt = wait_cnt - 2'd1;
      end
    end
    #1;
    read_dn  = respond && is_read;
    write_dn = respond && is_write;
    rdata    = (respond && is_read) ? mem[req_addr] : '0;
    if (respond && is_write) begin
      mem[req_addr] = req_data;
      writes++;
    end
  end

endmodule

`default_nettype wire
